// File: design/fm_acc_pkg.sv
// FM accumulator package with slot, channel config and stereo sample types

package fm_acc_pkg;

    // Six channels times four operators per round
    localparam int num_slots  = 24;
    // Width of the slot counter
    localparam int slot_cnt_w = $clog2(num_slots);

    // Decoded view of the current slot
    typedef struct packed {
        // Channel number 0, 1, 2, 4, 5 or 6
        logic [2:0] cur_ch;
        // Slot group 0 to 3
        logic [1:0] cur_op;
        // Operator entry flags, one per group
        logic       s1_enters;
        logic       s2_enters;
        logic       s3_enters;
        logic       s4_enters;
        // First slot of a round
        logic       zero;
    } slot_t;

    // Per-channel configuration
    typedef struct packed {
        // Algorithm 0 to 7
        logic [2:0] alg;
        // Bit 1 left enable, bit 0 right enable
        logic [1:0] rl;
    } ch_cfg_t;

    // Signed stereo pair
    typedef struct packed {
        logic signed [15:0] l;
        logic signed [15:0] r;
    } stereo_t;

    // One configuration write
    typedef struct packed {
        // Target channel
        logic [2:0] ch;
        ch_cfg_t    cfg;
    } cfg_wr_t;

endpackage

// File: design/slot_sequencer.sv
// Slot sequencer stepping the 24-slot channel and operator order on clock enable

module slot_sequencer
    import fm_acc_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clk_en,
    output slot_t slot
);

    // Slot index 0 to num_slots-1
    logic [slot_cnt_w-1:0] cnt;
    logic [slot_cnt_w-1:0] cnt_nxt;
    logic                  cnt_last;

    // Map a slot index to channel, group and flags
    function automatic slot_t decode_slot(input logic [slot_cnt_w-1:0] n);
        slot_t      s;
        logic [2:0] chi;
        logic [1:0] grp;
        chi = 3'(n % slot_cnt_w'(6));
        grp = 2'(n / slot_cnt_w'(6));
        s   = '0;
        // Channel 3 is skipped in the order
        case (chi)
            3'd0:    s.cur_ch = 3'd0;
            3'd1:    s.cur_ch = 3'd1;
            3'd2:    s.cur_ch = 3'd2;
            3'd3:    s.cur_ch = 3'd4;
            3'd4:    s.cur_ch = 3'd5;
            default: s.cur_ch = 3'd6;
        endcase
        s.cur_op = grp;
        // Groups run S1, S3, S2, S4
        case (grp)
            2'd0:    s.s1_enters = 1'b1;
            2'd1:    s.s3_enters = 1'b1;
            2'd2:    s.s2_enters = 1'b1;
            default: s.s4_enters = 1'b1;
        endcase
        s.zero = (n == '0);
        return s;
    endfunction

    assign cnt_last = (cnt == slot_cnt_w'(num_slots - 1));
    // Wrap at end of round
    assign cnt_nxt  = cnt_last ? '0 : cnt + 1'b1;

    // Decode of the next index is registered together with the counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            slot <= decode_slot('0);
        end else if (clk_en) begin
            cnt  <= cnt_nxt;
            slot <= decode_slot(cnt_nxt);
        end
    end

endmodule

// File: design/channel_regs.sv
// Channel register file holding algorithm and panning with lookup by current slot

module channel_regs
    import fm_acc_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cfg_we,
    input  cfg_wr_t cfg_wr,
    input  slot_t   slot,
    output ch_cfg_t cur_cfg
);

    // Indexed by channel number, entries 3 and 7 stay at reset value
    ch_cfg_t cfg_tbl [8];
    logic    wr_valid;

    // Channels 3 and 7 do not exist
    assign wr_valid = cfg_we && (cfg_wr.ch[1:0] != 2'b11);

    // Writes do not wait for clk_en
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                // Algorithm 0, both sides on
                cfg_tbl[i].alg <= 3'd0;
                cfg_tbl[i].rl  <= 2'b11;
            end
        end else if (wr_valid) begin
            cfg_tbl[cfg_wr.ch] <= cfg_wr.cfg;
        end
    end

    // Combinational lookup for the mixer
    assign cur_cfg = cfg_tbl[slot.cur_ch];

endmodule

// File: design/single_acc.sv
// Saturating accumulator summing one round of samples into a clamped output

module single_acc #(
    parameter int win   = 16,
    parameter int wout  = 16,
    parameter int acc_w = 19
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  logic signed [win-1:0]  op_result,
    input  logic                   sum_en,
    input  logic                   zero,
    output logic signed [wout-1:0] snd
);

    logic signed [acc_w-1:0] acc;
    logic signed [acc_w-1:0] acc_in;
    logic signed [wout-1:0]  acc_sat;
    logic                    ovf_pos;
    logic                    ovf_neg;

    // Sign extension into the wide accumulator
    assign acc_in = {{(acc_w - win){op_result[win-1]}}, op_result};

    // Bits above the output MSB must match the sign
    assign ovf_pos = ~acc[acc_w-1] & (|acc[acc_w-2:wout-1]);
    assign ovf_neg = acc[acc_w-1] & ~(&acc[acc_w-2:wout-1]);

    // Clamp to the signed output range
    always_comb begin
        if (ovf_pos) begin
            acc_sat = {1'b0, {(wout - 1){1'b1}}};
        end else if (ovf_neg) begin
            acc_sat = {1'b1, {(wout - 1){1'b0}}};
        end else begin
            acc_sat = acc[wout-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
            snd <= '0;
        end else if (clk_en) begin
            if (zero) begin
                // Round start, restart with this slot and publish old sum
                acc <= sum_en ? acc_in : '0;
                snd <= acc_sat;
            end else if (sum_en) begin
                acc <= acc + acc_in;
            end
        end
    end

endmodule

// File: design/acc_mix.sv
// Output mixer selecting carriers and ADPCM slots into left and right accumulators

module acc_mix
    import fm_acc_pkg::*;
#(
    parameter int win   = 16,
    parameter int wout  = 16,
    parameter int acc_w = 19
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clk_en,
    input  logic signed [13:0] op_result,
    input  slot_t              slot,
    input  ch_cfg_t            cur_cfg,
    input  stereo_t            adpcm_a,
    input  stereo_t            adpcm_b,
    output stereo_t            snd
);

    logic                   carrier;
    logic signed [15:0]     op_ext;
    logic signed [15:0]     a_l_sh;
    logic signed [15:0]     a_r_sh;
    logic signed [15:0]     b_l_sh;
    logic signed [15:0]     b_r_sh;
    logic signed [win-1:0]  acc_in_l;
    logic signed [win-1:0]  acc_in_r;
    logic                   acc_en_l;
    logic                   acc_en_r;
    logic signed [wout-1:0] snd_l;
    logic signed [wout-1:0] snd_r;

    // Carrier operators per algorithm
    always_comb begin
        case (cur_cfg.alg)
            3'd4:       carrier = slot.s2_enters | slot.s4_enters;
            3'd5, 3'd6: carrier = ~slot.s1_enters;
            3'd7:       carrier = 1'b1;
            // Algorithms 0 to 3 only output S4
            default:    carrier = slot.s4_enters;
        endcase
    end

    assign op_ext = 16'(op_result);

    // ADPCM gain, upper bits drop off
    assign a_l_sh = adpcm_a.l <<< 3;
    assign a_r_sh = adpcm_a.r <<< 3;
    assign b_l_sh = adpcm_b.l <<< 2;
    assign b_r_sh = adpcm_b.r <<< 2;

    // Group 0 of channels 2 and 6 carries ADPCM instead of FM
    always_comb begin
        case ({slot.cur_op, slot.cur_ch})
            {2'd0, 3'd2}: begin
                // ADPCM-A on both sides
                acc_in_l = win'(a_l_sh);
                acc_in_r = win'(a_r_sh);
                acc_en_l = 1'b1;
                acc_en_r = 1'b1;
            end
            {2'd0, 3'd6}: begin
                // ADPCM-B on both sides
                acc_in_l = win'(b_l_sh);
                acc_in_r = win'(b_r_sh);
                acc_en_l = 1'b1;
                acc_en_r = 1'b1;
            end
            default: begin
                acc_in_l = win'(op_ext);
                acc_in_r = win'(op_ext);
                // Panning gates each side
                acc_en_l = carrier & cur_cfg.rl[1];
                acc_en_r = carrier & cur_cfg.rl[0];
            end
        endcase
    end

    single_acc #(
        .win   (win),
        .wout  (wout),
        .acc_w (acc_w)
    ) u_left (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .op_result (acc_in_l),
        .sum_en    (acc_en_l),
        .zero      (slot.zero),
        .snd       (snd_l)
    );

    single_acc #(
        .win   (win),
        .wout  (wout),
        .acc_w (acc_w)
    ) u_right (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .op_result (acc_in_r),
        .sum_en    (acc_en_r),
        .zero      (slot.zero),
        .snd       (snd_r)
    );

    // Stereo output word
    assign snd.l = 16'(snd_l);
    assign snd.r = 16'(snd_r);

endmodule

// File: design/fm_acc_top.sv
// FM output stage top level joining slot sequencer, channel registers and mixer

module fm_acc_top
    import fm_acc_pkg::*;
#(
    // Mixer input width
    parameter int win   = 16,
    // Output sample width
    parameter int wout  = 16,
    // Accumulator width with headroom
    parameter int acc_w = 19
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clk_en,
    input  logic signed [13:0] op_result,
    input  stereo_t            adpcm_a,
    input  stereo_t            adpcm_b,
    input  logic               cfg_we,
    input  cfg_wr_t            cfg_wr,
    output slot_t              slot,
    output stereo_t            snd
);

    // Config of the channel in the current slot
    ch_cfg_t cur_cfg;

    slot_sequencer u_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .clk_en (clk_en),
        .slot   (slot)
    );

    channel_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_we  (cfg_we),
        .cfg_wr  (cfg_wr),
        .slot    (slot),
        .cur_cfg (cur_cfg)
    );

    acc_mix #(
        .win   (win),
        .wout  (wout),
        .acc_w (acc_w)
    ) u_mix (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .op_result (op_result),
        .slot      (slot),
        .cur_cfg   (cur_cfg),
        .adpcm_a   (adpcm_a),
        .adpcm_b   (adpcm_b),
        .snd       (snd)
    );

endmodule

// File: testbench/tb_fm_acc.sv
// Testbench for the FM output accumulator with a round-based reference model

module tb_fm_acc
    import fm_acc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 4;
    localparam int num_tests  = 6;
    localparam int max_rounds = 8;
    localparam int max_gap    = 3;
    // Worst case test length doubled for margin
    localparam int wd_time    =
        2 * num_tests * max_rounds * num_slots * (max_gap + 1) * clk_period;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               clk_en;
    logic signed [13:0] op_result;
    stereo_t            adpcm_a;
    stereo_t            adpcm_b;
    logic               cfg_we;
    cfg_wr_t            cfg_wr;
    slot_t              slot;
    stereo_t            snd;

    integer  seed = 32'h9527_a7e8;
    int      err_cnt = 0;
    int      pass_cnt = 0;
    int      test_num = 1;
    int      err_mark = 0;
    // Slot index of the next enabled edge, and of the one being driven
    int      idx;
    int      drv_idx;
    int      gap_max;
    // Model copy of the channel table
    ch_cfg_t cfg_model [8];
    // Inputs seen during the current round
    int      ops_rec [num_slots];
    ch_cfg_t cfgs_rec [num_slots];
    stereo_t a_rec;
    stereo_t b_rec;
    // Expected snd per finished round
    stereo_t exp_q [$];

    fm_acc_top #(
        .win   (16),
        .wout  (16),
        .acc_w (19)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .op_result (op_result),
        .adpcm_a   (adpcm_a),
        .adpcm_b   (adpcm_b),
        .cfg_we    (cfg_we),
        .cfg_wr    (cfg_wr),
        .slot      (slot),
        .snd       (snd)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input logic signed [31:0] actual,
                               input logic signed [31:0] expected, input string what);
        if (actual !== expected) begin
            err_cnt++;
            $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, actual,
                     expected);
        end else begin
            pass_cnt++;
        end
    endtask

    // Channel order within a slot group
    function automatic int chan_of_slot(input int n);
        case (n % 6)
            0:       return 0;
            1:       return 1;
            2:       return 2;
            3:       return 4;
            4:       return 5;
            default: return 6;
        endcase
    endfunction

    // One-hot {s1, s2, s3, s4} for a slot group in slot order S1 S3 S2 S4
    function automatic logic [3:0] entry_flags(input int grp);
        case (grp)
            0:       return 4'b1000;
            1:       return 4'b0010;
            2:       return 4'b0100;
            default: return 4'b0001;
        endcase
    endfunction

    function automatic logic signed [15:0] clamp16(input logic signed [18:0] s);
        if (s > 19'sd32767) begin
            return 16'sh7fff;
        end else if (s < -19'sd32768) begin
            return 16'sh8000;
        end
        return 16'(s);
    endfunction

    // Sum of one round as the mixer should produce it
    function automatic stereo_t expected_mix(input int ops [num_slots],
                                             input ch_cfg_t cfgs [num_slots],
                                             input stereo_t a, input stereo_t b);
        logic signed [18:0] sum_l;
        logic signed [18:0] sum_r;
        logic signed [15:0] vl;
        logic signed [15:0] vr;
        logic               car;
        int                 grp;
        int                 pos;
        stereo_t            res;
        sum_l = '0;
        sum_r = '0;
        for (int n = 0; n < num_slots; n++) begin
            grp = n / 6;
            pos = n % 6;
            // Groups in slot order are S1, S3, S2, S4
            case (cfgs[n].alg)
                3'd4:       car = (grp == 2) || (grp == 3);
                3'd5, 3'd6: car = (grp != 0);
                3'd7:       car = 1'b1;
                default:    car = (grp == 3);
            endcase
            if (grp == 0 && pos == 2) begin
                // ADPCM-A times 8 wrapped to 16 bits
                vl = 16'(a.l * 8);
                vr = 16'(a.r * 8);
                sum_l = sum_l + 19'(vl);
                sum_r = sum_r + 19'(vr);
            end else if (grp == 0 && pos == 5) begin
                vl = 16'(b.l * 4);
                vr = 16'(b.r * 4);
                sum_l = sum_l + 19'(vl);
                sum_r = sum_r + 19'(vr);
            end else begin
                vl = 16'(ops[n]);
                if (car && cfgs[n].rl[1]) sum_l = sum_l + 19'(vl);
                if (car && cfgs[n].rl[0]) sum_r = sum_r + 19'(vl);
            end
        end
        res.l = clamp16(sum_l);
        res.r = clamp16(sum_r);
        return res;
    endfunction

    function automatic int rand_op();
        int r;
        r = $random(seed);
        return r % 8192;
    endfunction

    // One enabled slot after a random number of idle cycles
    task automatic drive_slot(input int op);
        int gap;
        gap = (gap_max > 0) ? ($unsigned($random(seed)) % (gap_max + 1)) : 0;
        repeat (gap) begin
            clk_en    = 1'b0;
            // Junk on the bus while idle
            op_result = 14'($random(seed));
            @(posedge clk);
            #1;
        end
        check_value(slot.zero, (idx == 0), "slot zero flag");
        check_value(slot.cur_ch, chan_of_slot(idx), "slot channel");
        check_value(slot.cur_op, idx / 6, "slot operator group");
        check_value({slot.s1_enters, slot.s2_enters, slot.s3_enters, slot.s4_enters},
                    entry_flags(idx / 6), "slot entry flags");
        clk_en        = 1'b1;
        op_result     = 14'(op);
        drv_idx       = idx;
        ops_rec[idx]  = op;
        cfgs_rec[idx] = cfg_model[chan_of_slot(idx)];
        if (idx == 2) a_rec = adpcm_a;
        if (idx == 5) b_rec = adpcm_b;
        if (idx == num_slots - 1) begin
            exp_q.push_back(expected_mix(ops_rec, cfgs_rec, a_rec, b_rec));
            idx = 0;
        end else begin
            idx++;
        end
        @(posedge clk);
        #1;
        clk_en = 1'b0;
    endtask

    task automatic run_rounds(input int n);
        repeat (n * num_slots) drive_slot(rand_op());
    endtask

    task automatic run_fixed(input int n, input int op);
        repeat (n * num_slots) drive_slot(op);
    endtask

    // Write with clk_en held low
    task automatic write_cfg(input int ch, input int alg, input int rl);
        clk_en         = 1'b0;
        cfg_we         = 1'b1;
        cfg_wr.ch      = 3'(ch);
        cfg_wr.cfg.alg = 3'(alg);
        cfg_wr.cfg.rl  = 2'(rl);
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
        if (ch != 3 && ch != 7) cfg_model[ch] = cfg_wr.cfg;
    endtask

    // Run into the next round start so the last round gets compared
    task automatic close_test(input string name);
        do begin
            drive_slot(rand_op());
        end while (idx != 1);
        repeat (2) @(posedge clk);
        #1;
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("Round result was never compared in test %0d", test_num);
        end
        $display("Test %0d %s: %s, %0d errors", test_num, name,
                 (err_cnt == err_mark) ? "ok" : "failed", err_cnt - err_mark);
        test_num++;
        err_mark = err_cnt;
    endtask

    // Compares snd one clock after each round start and checks that it holds in between
    initial begin : compare_proc
        stereo_t exp_snd;
        stereo_t held;
        logic    pending;
        held    = '0;
        pending = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                held    = '0;
                pending = 1'b0;
            end else begin
                if (pending) begin
                    if (exp_q.size() == 0) begin
                        err_cnt++;
                        $display("No expected result queued at %0d ns", $time);
                    end else begin
                        exp_snd = exp_q.pop_front();
                        check_value(snd.l, exp_snd.l, "snd left");
                        check_value(snd.r, exp_snd.r, "snd right");
                    end
                    held = snd;
                end else begin
                    check_value(snd.l, held.l, "held snd left");
                    check_value(snd.r, held.r, "held snd right");
                end
                pending = clk_en && (drv_idx == 0);
            end
        end
    end

    initial begin : watchdog
        #(wd_time + 16 * clk_period);
        $display("Timeout: the test sequence did not finish within %0d ns", wd_time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main_seq
        int i;
        rst_n     = 1'b0;
        clk_en    = 1'b0;
        op_result = '0;
        adpcm_a   = '0;
        adpcm_b   = '0;
        cfg_we    = 1'b0;
        cfg_wr    = '0;
        idx       = 0;
        drv_idx   = 0;
        gap_max   = 0;
        for (i = 0; i < 8; i++) begin
            cfg_model[i].alg = 3'd0;
            cfg_model[i].rl  = 2'b11;
        end
        // Cleared accumulator goes out at the first round start
        exp_q.push_back('0);
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset defaults sum only S4 on both sides
        check_value(snd.l, 0, "snd left after reset");
        check_value(snd.r, 0, "snd right after reset");
        check_value(slot.zero, 1, "slot zero flag after reset");
        run_rounds(2);
        close_test("reset state");

        // Two passes cover all eight algorithms
        for (i = 0; i < 6; i++) write_cfg(chan_of_slot(i), (i + 2) % 8, 3);
        run_rounds(2);
        for (i = 0; i < 6; i++) write_cfg(chan_of_slot(i), (i + 5) % 8, 3);
        run_rounds(2);
        close_test("algorithm sweep");

        // rl 0 to 3 spread over the channels
        for (i = 0; i < 6; i++) write_cfg(chan_of_slot(i), 7, i % 4);
        run_rounds(2);
        for (i = 0; i < 6; i++) write_cfg(chan_of_slot(i), 4, (i + 2) % 4);
        run_rounds(2);
        close_test("panning");

        // FM muted everywhere before the ADPCM channels go to alg 7 on both sides
        for (i = 0; i < 6; i++) write_cfg(chan_of_slot(i), 0, 0);
        adpcm_a = $random(seed);
        adpcm_b = $random(seed);
        run_rounds(1);
        write_cfg(2, 7, 3);
        write_cfg(6, 7, 3);
        adpcm_a = $random(seed);
        adpcm_b = $random(seed);
        run_rounds(1);
        close_test("adpcm substitution");

        // Every slot summed with extreme values
        for (i = 0; i < 6; i++) write_cfg(chan_of_slot(i), 7, 3);
        adpcm_a.l = 16'h0fff;
        adpcm_a.r = 16'h0fff;
        adpcm_b.l = 16'h1fff;
        adpcm_b.r = 16'h1fff;
        run_fixed(1, 8191);
        adpcm_a.l = 16'hf000;
        adpcm_a.r = 16'hf000;
        adpcm_b.l = 16'he000;
        adpcm_b.r = 16'he000;
        run_fixed(1, -8192);
        close_test("saturation");

        // Idle gaps with config writes in between slots
        gap_max = max_gap;
        adpcm_a = $random(seed);
        adpcm_b = $random(seed);
        repeat (9) begin
            write_cfg(chan_of_slot($unsigned($random(seed)) % 6),
                      $unsigned($random(seed)) % 8, $unsigned($random(seed)) % 4);
            repeat (8) drive_slot(rand_op());
        end
        close_test("irregular clock enable");
        gap_max = 0;

        $display("Checks passed: %0d, errors: %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
design/fm_acc_pkg.sv
design/slot_sequencer.sv
design/channel_regs.sv
design/single_acc.sv
design/acc_mix.sv
design/fm_acc_top.sv
testbench/tb_fm_acc.sv

// File: Makefile
# Verilator build and run for the FM accumulator testbench

TOP := tb_fm_acc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f flist.f -Mdir obj_dir

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
